/* sim.f */
+incdir+include
rtl/cachePkg.sv
rtl/tagArray.sv
rtl/dataArray.sv
rtl/mainMemory.sv
rtl/fillController.sv
rtl/cacheTop.sv
testbench/cacheTb.sv

/* include/cacheTbUtil.svh */
`ifndef CACHE_TB_UTIL_SVH
`define CACHE_TB_UTIL_SVH

// xorshift32 state for the random phase
logic [31:0] rngState = 32'hff2cc637;

function automatic logic [31:0] nextRandom();
	logic [31:0] x;
	x = rngState;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rngState = x;
	return x;
endfunction

////////////////////
// reference model
////////////////////

// written memory words by word address
// unwritten words read as zero
dataT refMem [int];
// tag per filled block
// no entry means an invalid block
tagT refTag [int];

// tag in 15..11, index in 10..4, word in 3..1
function automatic addrT makeAddr(input tagT t, input indexT i, input wordSelT w);
	return {t, i, w, 1'b0};
endfunction

// expected outcome of a request
// taken before the request changes the model
function automatic void refExpect(input logic wr, input addrT a, output dataT word,
		output logic hitNow, output logic miss);
	int idx;
	logic present;
	idx = int'(a[10:4]);
	present = refTag.exists(idx) && (refTag[idx] == a[15:11]);
	// write through keeps the cached copy equal to memory
	word = refMem.exists(int'(a[15:1])) ? refMem[int'(a[15:1])] : '0;
	// only reads allocate
	miss = !wr && !present;
	// a read always hits once its fill is over
	hitNow = wr ? present : 1'b1;
endfunction

// writes land in memory only
// reads leave their block filled
function automatic void refUpdate(input logic wr, input addrT a, input dataT d);
	if (wr) begin
		refMem[int'(a[15:1])] = d;
	end else begin
		refTag[int'(a[10:4])] = a[15:11];
	end
endfunction

////////////////////
// compare tasks
////////////////////

task automatic checkData(input dataT got, input dataT exp, input string what);
	if (got !== exp) begin
		$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
		stopOnFailure();
	end
endtask

task automatic checkLevel(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		$display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
		stopOnFailure();
	end
endtask

task automatic checkCount(input int got, input int exp, input string what);
	if (got != exp) begin
		$display("[FAIL] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		stopOnFailure();
	end
endtask

`endif

/* testbench/cacheTb.sv */
`include "cache_macros.svh"

module cacheTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cachePkg::*;

	// miss cycle plus eight issue cycles plus the read latency
	localparam int fillStall = 1 + `CACHE_WORDS + `MEM_READ_LATENCY;
	localparam int stallLimit = 4 * fillStall;

	logic clk;
	logic rst;
	logic cacheEnable;
	logic write;
	addrT address;
	dataT dataIn;
	dataT dataOut;
	logic stall;
	logic reqValid;
	logic hit;

	// expectation for the request in flight
	dataT expWord;
	logic expHit;
	logic expCheckWord;
	int reqCount;
	int checksDone;

	task automatic stopOnFailure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	`include "cacheTbUtil.svh"

	cacheTop dut0 (
		.clk(clk),
		.rst(rst),
		.cacheEnable(cacheEnable),
		.write(write),
		.address(address),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.stall(stall),
		.reqValid(reqValid),
		.hit(hit)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	////////////////////
	// comparing process
	////////////////////

	// outputs are read at the falling edge, half a cycle after inputs move
	always @(negedge clk) begin
		if (!rst && !cacheEnable) begin
			checkLevel(stall, 1'b0, "stall while disabled");
			checkLevel(hit, 1'b0, "hit while disabled");
			checkLevel(reqValid, 1'b0, "reqValid while disabled");
		end else if (!rst && !stall) begin
			// response cycle of the held request
			checkLevel(reqValid, 1'b1, "reqValid");
			checkLevel(hit, expHit, "hit");
			if (expCheckWord) begin
				checkData(dataOut, expWord, "dataOut");
			end
			checksDone++;
		end
	end

	// one request, held until stall falls
	task automatic doRequest(input logic wr, input addrT a, input dataT d);
		logic miss;
		int stallCycles;
		@(posedge clk);
		refExpect(wr, a, expWord, expHit, miss);
		// write misses leave a stale word on dataOut
		expCheckWord = !wr || expHit;
		cacheEnable <= 1'b1;
		write <= wr;
		address <= a;
		dataIn <= d;
		reqCount++;
		stallCycles = 0;
		@(negedge clk);
		while (stall) begin
			stallCycles++;
			if (stallCycles > stallLimit) begin
				$display("timeout: stall stayed high over %0d cycles at address %h",
					stallLimit, a);
				stopOnFailure();
			end
			@(negedge clk);
		end
		checkCount(stallCycles, miss ? fillStall : 0, "stall cycles");
		refUpdate(wr, a, d);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			cacheEnable <= 1'b0;
			write <= 1'b0;
		end
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial begin
		logic [31:0] r;
		addrT a;
		rst = 1'b1;
		cacheEnable = 1'b0;
		write = 1'b0;
		address = '0;
		dataIn = '0;
		expWord = '0;
		expHit = 1'b0;
		expCheckWord = 1'b0;
		reqCount = 0;
		checksDone = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// quiet outputs, then a cold miss returning zero
		idleCycles(4);
		doRequest(1'b0, makeAddr(5'd3, 7'd10, 3'd2), '0);
		// write miss goes around the cache, the read must refill
		doRequest(1'b1, makeAddr(5'd7, 7'd20, 3'd5), 16'hbeef);
		doRequest(1'b0, makeAddr(5'd7, 7'd20, 3'd5), '0);
		idleCycles(2);
		// fill a block with an address pattern and read it back
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			a = makeAddr(5'd9, 7'd33, wordSelT'(w));
			doRequest(1'b1, a, {a[7:0], a[15:8]} ^ 16'hc3a5);
		end
		for (int w = 0; w < `CACHE_WORDS; w++) begin
			doRequest(1'b0, makeAddr(5'd9, 7'd33, wordSelT'(w)), '0);
		end
		// write hit, eviction by another tag, refill from memory
		doRequest(1'b1, makeAddr(5'd9, 7'd33, 3'd3), 16'h1234);
		doRequest(1'b0, makeAddr(5'd9, 7'd33, 3'd3), '0);
		doRequest(1'b0, makeAddr(5'd10, 7'd33, 3'd0), '0);
		doRequest(1'b0, makeAddr(5'd9, 7'd33, 3'd3), '0);
		// conflict miss on index 10
		doRequest(1'b1, makeAddr(5'd4, 7'd10, 3'd2), 16'h0f0f);
		doRequest(1'b0, makeAddr(5'd4, 7'd10, 3'd2), '0);
		doRequest(1'b0, makeAddr(5'd3, 7'd10, 3'd2), '0);
		// random mix over four indexes and four tags, a quarter are writes
		for (int n = 0; n < 200; n++) begin
			r = nextRandom();
			a = makeAddr(5'd1 + r[1:0], 7'd40 + r[3:2], r[6:4]);
			doRequest(r[8:7] == 2'b00, a, r[31:16]);
			if (r[9] && r[10]) begin
				idleCycles(1);
			end
		end
		idleCycles(3);
		if (checksDone == reqCount) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("checker saw %0d responses for %0d requests", checksDone, reqCount);
			stopOnFailure();
		end
	end

endmodule

/* rtl/cacheTop.sv */
`include "cache_macros.svh"

module cacheTop (
	input logic clk,
	input logic rst,
	input logic cacheEnable,
	input logic write,
	input cachePkg::addrT address,
	input cachePkg::dataT dataIn,
	output cachePkg::dataT dataOut,
	output logic stall,
	output logic reqValid,
	output logic hit
);
	import cachePkg::*;

	// controller to memory
	addrT memAddr;
	logic memRead;
	logic memWrite;
	// memory back to controller
	dataT memData;
	logic memValid;
	// controller to the data and tag arrays
	wordSelT arrayWord;
	logic arrayWrite;
	dataT arrayWriteData;
	logic tagWrite;
	logic tagHit;

	////////////////////
	// miss FSM and port steering
	////////////////////

	fillController ctrl0 (
		.clk(clk),
		.rst(rst),
		.cacheEnable(cacheEnable),
		.write(write),
		.address(address),
		.dataIn(dataIn),
		.tagHit(tagHit),
		.memData(memData),
		.memValid(memValid),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.arrayWord(arrayWord),
		.arrayWrite(arrayWrite),
		.arrayWriteData(arrayWriteData),
		.tagWrite(tagWrite),
		.stall(stall),
		.reqValid(reqValid),
		.hit(hit)
	);

	////////////////////
	// storage
	////////////////////

	// index comes straight off the address, request is held during a fill
	dataArray data0 (
		.clk(clk),
		.rst(rst),
		.index(address[`CACHE_WORD_W+`CACHE_INDEX_W:`CACHE_WORD_W+1]),
		.arrayWord(arrayWord),
		.arrayWrite(arrayWrite),
		.arrayWriteData(arrayWriteData),
		.dataOut(dataOut)
	);

	tagArray tag0 (
		.clk(clk),
		.rst(rst),
		.index(address[`CACHE_WORD_W+`CACHE_INDEX_W:`CACHE_WORD_W+1]),
		.tag(address[`CACHE_ADDR_W-1:`CACHE_ADDR_W-`CACHE_TAG_W]),
		.tagWrite(tagWrite),
		.tagHit(tagHit)
	);

	// write data always comes from the requester
	mainMemory mem0 (
		.clk(clk),
		.rst(rst),
		.memAddr(memAddr),
		.memRead(memRead),
		.memWrite(memWrite),
		.dataIn(dataIn),
		.memData(memData),
		.memValid(memValid)
	);

endmodule

/* rtl/fillController.sv */
`include "cache_macros.svh"

module fillController (
	input logic clk,
	input logic rst,
	input logic cacheEnable,
	input logic write,
	input cachePkg::addrT address,
	input cachePkg::dataT dataIn,
	input logic tagHit,
	input cachePkg::dataT memData,
	input logic memValid,
	output cachePkg::addrT memAddr,
	output logic memRead,
	output logic memWrite,
	output cachePkg::wordSelT arrayWord,
	output logic arrayWrite,
	output cachePkg::dataT arrayWriteData,
	output logic tagWrite,
	output logic stall,
	output logic reqValid,
	output logic hit
);
	import cachePkg::*;

	localparam wordSelT lastWord = wordSelT'(`CACHE_WORDS - 1);

	fillStateT state;
	fillStateT nextState;
	// next word read to send during issue
	wordSelT issueCnt;
	// next word expected back from memory
	wordSelT recvCnt;
	logic idle;
	logic readMiss;
	logic lastIssue;
	logic lastReturn;
	// block base, the request address with the word and byte bits dropped
	logic [`CACHE_ADDR_W-`CACHE_WORD_W-2:0] blockBase;

	assign idle = (state == fillIdle);
	assign blockBase = address[`CACHE_ADDR_W-1:`CACHE_WORD_W+1];
	// only reads allocate, write misses go around the cache
	assign readMiss = cacheEnable && !write && !tagHit;
	assign lastIssue = (issueCnt == lastWord);
	// eighth word of the block is coming back now
	assign lastReturn = !idle && memValid && (recvCnt == lastWord);

	////////////////////
	// state and counters
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fillIdle;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || idle) begin
			// both counters start at word 0 for every fill
			issueCnt <= '0;
			recvCnt <= '0;
		end else begin
			// one read per cycle while issuing
			if (state == fillIssue) begin
				issueCnt <= issueCnt + 1'b1;
			end
			// returns overlap the issue phase, so count them in any fill state
			if (memValid) begin
				recvCnt <= recvCnt + 1'b1;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			fillIdle: begin
				if (readMiss) begin
					nextState = fillIssue;
				end
			end
			fillIssue: begin
				// eight reads then wait out the pipeline
				if (lastIssue) begin
					nextState = fillDrain;
				end
			end
			fillDrain: begin
				if (lastReturn) begin
					nextState = fillIdle;
				end
			end
			default: nextState = fillIdle;
		endcase
	end

	////////////////////
	// memory and array steering
	////////////////////

	always_comb begin
		if (idle) begin
			// pass the request through, writes go to memory every time
			memAddr = address;
			memRead = 1'b0;
			memWrite = cacheEnable && write;
			arrayWord = address[`CACHE_WORD_W:1];
			// write hit updates the cached copy too
			arrayWrite = cacheEnable && write && tagHit;
			arrayWriteData = dataIn;
		end else begin
			// walk the block from word 0, byte bit stays zero
			memAddr = {blockBase, issueCnt, 1'b0};
			memRead = (state == fillIssue);
			memWrite = 1'b0;
			// each returned word lands at the receive count
			arrayWord = recvCnt;
			arrayWrite = memValid;
			arrayWriteData = memData;
		end
	end

	// tag and valid go in with the last word
	assign tagWrite = lastReturn;

	////////////////////
	// requester outputs
	////////////////////

	// stall rises in the miss cycle and holds until back in idle
	assign stall = (idle && readMiss) || !idle;
	assign reqValid = cacheEnable && idle;
	assign hit = reqValid && tagHit;

endmodule

/* rtl/mainMemory.sv */
`include "cache_macros.svh"

module mainMemory (
	input logic clk,
	input logic rst,
	input cachePkg::addrT memAddr,
	input logic memRead,
	input logic memWrite,
	input cachePkg::dataT dataIn,
	output cachePkg::dataT memData,
	output logic memValid
);
	import cachePkg::*;

	// one word per even byte address
	localparam int memWords = 2 ** (`CACHE_ADDR_W - 1);
	localparam int lat = `MEM_READ_LATENCY;

	// word store, all zero at start
	dataT store [memWords] = '{default: '0};
	// read pipeline, stage lat-1 drives the outputs
	dataT dataPipe [lat];
	logic [lat-1:0] validPipe;
	logic [`CACHE_ADDR_W-2:0] wordAddr;

	// byte bit is dropped
	assign wordAddr = memAddr[`CACHE_ADDR_W-1:1];

	////////////////////
	// write port
	////////////////////

	// single cycle write
	always_ff @(posedge clk) begin
		if (memWrite) begin
			store[wordAddr] <= dataIn;
		end
	end

	////////////////////
	// read pipeline
	////////////////////

	// data moves every cycle, valid qualifies it
	always_ff @(posedge clk) begin
		dataPipe[0] <= store[wordAddr];
		for (int s = 1; s < lat; s++) begin
			dataPipe[s] <= dataPipe[s-1];
		end
	end

	// a read with a write in the same cycle is ignored
	always_ff @(posedge clk) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[lat-2:0], memRead && !memWrite};
		end
	end

	// valid is a one cycle pulse per read, lat cycles after the strobe
	assign memData = dataPipe[lat-1];
	assign memValid = validPipe[lat-1];

endmodule

/* rtl/dataArray.sv */
`include "cache_macros.svh"

module dataArray (
	input logic clk,
	input logic rst,
	input cachePkg::indexT index,
	input cachePkg::wordSelT arrayWord,
	input logic arrayWrite,
	input cachePkg::dataT arrayWriteData,
	output cachePkg::dataT dataOut
);
	import cachePkg::*;

	// block by word storage, 1024 words in all
	dataT store [`CACHE_BLOCKS][`CACHE_WORDS];

	////////////////////
	// write port
	////////////////////

	// one word per cycle at the selected block and word
	// nothing is written while reset is held
	always_ff @(posedge clk) begin
		if (arrayWrite && !rst) begin
			store[index][arrayWord] <= arrayWriteData;
		end
	end

	////////////////////
	// read port
	////////////////////

	// combinational read so a hit returns in the request cycle
	assign dataOut = store[index][arrayWord];

endmodule

/* rtl/tagArray.sv */
`include "cache_macros.svh"

module tagArray (
	input logic clk,
	input logic rst,
	input cachePkg::indexT index,
	input cachePkg::tagT tag,
	input logic tagWrite,
	output logic tagHit
);
	import cachePkg::*;

	// one valid bit per block
	logic [`CACHE_BLOCKS-1:0] valid;
	// stored tag per block
	tagT tags [`CACHE_BLOCKS];

	////////////////////
	// valid bits
	////////////////////

	// all blocks empty after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (tagWrite) begin
			valid[index] <= 1'b1;
		end
	end

	////////////////////
	// tag storage
	////////////////////

	// the tag is only trusted when valid is set
	always_ff @(posedge clk) begin
		if (tagWrite) begin
			tags[index] <= tag;
		end
	end

	// compare against the incoming address tag
	assign tagHit = valid[index] && (tags[index] == tag);

endmodule

/* rtl/cachePkg.sv */
`include "cache_macros.svh"

package cachePkg;

	////////////////////
	// bus and field types
	////////////////////

	// byte address
	// tag in 15..11, index in 10..4, word in 3..1
	typedef logic [`CACHE_ADDR_W-1:0] addrT;

	// one memory or cache word
	typedef logic [`CACHE_DATA_W-1:0] dataT;

	typedef logic [`CACHE_TAG_W-1:0] tagT;
	typedef logic [`CACHE_INDEX_W-1:0] indexT;
	typedef logic [`CACHE_WORD_W-1:0] wordSelT;

	////////////////////
	// miss handling FSM
	////////////////////

	// fillIdle serves hits and writes
	// fillIssue sends the eight word reads
	// fillDrain waits for the last returns
	typedef enum logic [1:0] {
		fillIdle = 2'd0,
		fillIssue = 2'd1,
		fillDrain = 2'd2
	} fillStateT;

endpackage

/* include/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

////////////////////
// address and data widths
////////////////////

// byte address, bit 0 unused
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 16

////////////////////
// cache geometry
////////////////////

// address bits 10..4 pick the block
`define CACHE_INDEX_W 7
// address bits 3..1 pick the word inside a block
`define CACHE_WORD_W 3
// address bits 15..11 are kept as tag
`define CACHE_TAG_W 5
`define CACHE_BLOCKS 128
`define CACHE_WORDS 8

////////////////////
// main memory timing
////////////////////

// cycles from read strobe to data valid
`define MEM_READ_LATENCY 4

`endif
